//--- include/coreRrv_cfg.svh
`ifndef CORERRV_CFG_SVH
`define CORERRV_CFG_SVH

// ======================================================================
// memory map
// ======================================================================
`define IMEM_BASE         32'h0000_0000 // instruction memory window
`define IMEM_WORDS        1024          // 4 KB of instructions
`define DMEM_BASE         32'h0000_1000 // data memory window
`define DMEM_WORDS        1024          // 4 KB of data

// ======================================================================
// keyboard control registers
// ======================================================================
`define CR_KBD_DATA       32'h0000_FF00 // read returns head byte and pops
`define CR_KBD_READY      32'h0000_FF04 // bit 0 = byte available
`define CR_KBD_SCANF_EN   32'h0000_FF08 // bit 0 = accept new frames

// keyboard byte queue
`define KBD_FIFO_DEPTH    8             // scan codes held before drop

`endif

//--- hw/coreRrvPkg.sv
`default_nettype none

package coreRrvPkg;

   // ======================================================================
   // basic widths
   // ======================================================================
   typedef logic [31:0] tWord;          // data or byte address
   typedef logic [3:0]  tByteEn;        // one bit per byte lane
   typedef logic [7:0]  tTileId;        // mesh tile number
   typedef logic [7:0]  tKbdByte;       // ps/2 scan code

   // ======================================================================
   // fabric transaction
   // ======================================================================
   typedef enum logic [1:0] {
      FAB_RD     = 2'd0,                // read request
      FAB_WR     = 2'd1,                // posted write, no response
      FAB_RD_RSP = 2'd2                 // read data back to requestor
   } tFabOpcode;

   typedef struct packed {
      tFabOpcode opcode;                // what to do
      tTileId    srcTileId;             // requesting tile
      tTileId    tgtTileId;             // tile that owns the address
      tWord      address;               // byte address in target tile
      tWord      data;                  // write data or read response
   } tTileTrans;                        // 82 bits

   // ======================================================================
   // ps/2 receiver
   // ======================================================================
   typedef enum logic [1:0] {
      IDLE   = 2'd0,                    // wait for start bit
      SHIFT  = 2'd1,                    // eight data bits, lsb first
      PARITY = 2'd2,                    // odd parity bit
      STOP   = 2'd3                     // stop bit, then judge frame
   } tPs2State;

endpackage

`default_nettype wire

//--- hw/dMemIf.sv
`default_nettype none
`timescale 1ns/100ps

// core data memory port, request in Q103 and response in Q105
interface dMemIf;
   import coreRrvPkg::*;

   logic   rdEn;                        // load in this cycle
   logic   wrEn;                        // store in this cycle
   tWord   address;                     // byte address
   tWord   wrData;                      // store data, lane aligned
   tByteEn byteEn;                      // lanes written on store
   tWord   rdRsp;                       // load data two cycles later

   // requestor side
   modport core (
      output rdEn,
      output wrEn,
      output address,
      output wrData,
      output byteEn,
      input  rdRsp
   );

   // memory side
   modport mem (
      input  rdEn,
      input  wrEn,
      input  address,
      input  wrData,
      input  byteEn,
      output rdRsp
   );

endinterface

`default_nettype wire

//--- hw/ps2KbdCtrl.sv
`default_nettype none
`timescale 1ns/100ps
`include "coreRrv_cfg.svh"

module ps2KbdCtrl (
   input  logic                Clock,
   input  logic                arstN,
   input  logic                kbdClk,       // clock line from keyboard
   input  logic                kbdData,      // data line from keyboard
   input  logic                kbdPop,       // drop head byte
   input  logic                kbdScanfEn,   // accept new frames
   output coreRrvPkg::tKbdByte kbdByte,      // head of queue
   output logic                kbdReady      // queue not empty
);
   import coreRrvPkg::*;

   localparam int DEPTH = `KBD_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   logic [1:0]       kbdClkSync;             // two-flop synchronizer
   logic [1:0]       kbdDataSync;
   logic             kbdClkDly;              // previous synced clock
   logic             fallEdge;               // one frame bit per fall
   tPs2State         state;
   logic [2:0]       bitCnt;                 // data bit index
   tKbdByte          shiftReg;               // frame assembly
   logic             parityBit;
   logic             frameGood;              // push request, one cycle

   tKbdByte          fifoMem [DEPTH];
   logic [PTR_W-1:0] wrPtr;
   logic [PTR_W-1:0] rdPtr;
   logic [PTR_W:0]   count;                  // 0 .. DEPTH
   logic             fifoFull;
   logic             push;
   logic             pop;

   // ======================================================================
   // line synchronizer and edge detect
   // ======================================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         kbdClkSync  <= 2'b11;               // idle lines are high
         kbdDataSync <= 2'b11;
         kbdClkDly   <= 1'b1;
      end else begin
         kbdClkSync  <= {kbdClkSync[0], kbdClk};
         kbdDataSync <= {kbdDataSync[0], kbdData};
         kbdClkDly   <= kbdClkSync[1];
      end
   end

   assign fallEdge = kbdClkDly && !kbdClkSync[1];

   // ======================================================================
   // frame FSM
   // ======================================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         state     <= IDLE;
         bitCnt    <= '0;
         frameGood <= 1'b0;
      end else begin
         frameGood <= 1'b0;                  // pulse
         if (fallEdge) begin
            case (state)
               IDLE: begin
                  if (!kbdDataSync[1]) begin // start bit
                     state  <= SHIFT;
                     bitCnt <= '0;
                  end
               end
               SHIFT: begin
                  bitCnt <= bitCnt + 1'b1;
                  if (bitCnt == 3'd7)
                     state <= PARITY;
               end
               PARITY: state <= STOP;
               STOP: begin
                  state <= IDLE;
                  // stop high, odd ones count, scanf on
                  frameGood <= kbdDataSync[1] && (^{shiftReg, parityBit}) && kbdScanfEn;
               end
               default: state <= IDLE;
            endcase
         end
      end
   end

   // frame payload and queue storage
   always_ff @(posedge Clock) begin
      if (fallEdge && state == SHIFT)
         shiftReg <= {kbdDataSync[1], shiftReg[7:1]}; // lsb arrives first
      if (fallEdge && state == PARITY)
         parityBit <= kbdDataSync[1];
      if (push)
         fifoMem[wrPtr] <= shiftReg;
   end

   // ======================================================================
   // byte FIFO
   // ======================================================================
   assign fifoFull = (count == (PTR_W+1)'(DEPTH));
   assign push     = frameGood && !fifoFull; // full queue drops the byte
   assign pop      = kbdPop && kbdReady;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push)
            wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (pop)
            rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign kbdByte  = fifoMem[rdPtr];
   assign kbdReady = (count != '0);

   // wrapper must only pop a byte it has seen ready
   popNotEmpty: assert property (@(posedge Clock) disable iff (!arstN)
      kbdPop |-> kbdReady);

endmodule

`default_nettype wire

//--- hw/coreRrvMemWrap.sv
`default_nettype none
`timescale 1ns/100ps
`include "coreRrv_cfg.svh"

module coreRrvMemWrap (
   input  logic                      Clock,
   input  logic                      arstN,
   input  coreRrvPkg::tTileId        localTileId,
   // instruction fetch
   input  coreRrvPkg::tWord          pc,             // Q100
   output coreRrvPkg::tWord          instruction,    // Q101
   // core data port
   dMemIf.mem                        dMem,
   // fabric
   input  logic                      inFabricValid,  // Q503
   input  var coreRrvPkg::tTileTrans inFabric,
   output logic                      coreRrvReady,
   output logic                      outFabricValid, // Q505
   output coreRrvPkg::tTileTrans     outFabric,
   input  logic                      fabReady,
   // keyboard
   input  coreRrvPkg::tKbdByte       kbdByte,
   input  logic                      kbdReady,
   output logic                      kbdPop,
   output logic                      kbdScanfEn
);
   import coreRrvPkg::*;

   localparam int IMEM_AW = $clog2(`IMEM_WORDS);
   localparam int DMEM_AW = $clog2(`DMEM_WORDS);

   tWord      iMemArr [`IMEM_WORDS];
   tWord      dMemArr [`DMEM_WORDS];

   logic      coreAccess;                    // core owns this cycle
   logic      coreInDmem;
   logic      coreRdKbdData;
   tWord      coreRdWordQ104;

   logic      fabAccept;                     // request for this tile taken
   logic      fabRd;
   logic      fabWr;
   logic      fabInImem;
   logic      fabInDmem;
   logic      fabRspValidQ504;
   tTileTrans fabRspQ504;
   logic      outAdvance;                    // output slot free or draining

   function automatic logic inRange(tWord addr, tWord base, int unsigned words);
      return (addr >= base) && (addr < base + tWord'(words * 4));
   endfunction

   // ======================================================================
   // address decode
   // ======================================================================
   assign coreAccess    = dMem.rdEn || dMem.wrEn;
   assign coreInDmem    = inRange(dMem.address, `DMEM_BASE, `DMEM_WORDS);
   assign coreRdKbdData = dMem.rdEn && (dMem.address == `CR_KBD_DATA);

   assign fabInImem  = inRange(inFabric.address, `IMEM_BASE, `IMEM_WORDS);
   assign fabInDmem  = inRange(inFabric.address, `DMEM_BASE, `DMEM_WORDS);
   assign fabAccept  = inFabricValid && coreRrvReady && (inFabric.tgtTileId == localTileId);
   assign fabRd      = fabAccept && (inFabric.opcode == FAB_RD);
   assign fabWr      = fabAccept && (inFabric.opcode == FAB_WR);

   // core first, and no room once both stages hold a response
   assign coreRrvReady = !coreAccess && !(fabRspValidQ504 && outFabricValid);
   assign outAdvance   = !outFabricValid || fabReady;

   // ======================================================================
   // memory arrays
   // ======================================================================
   always_ff @(posedge Clock) begin
      if (fabWr && fabInImem)
         iMemArr[inFabric.address[IMEM_AW+1:2]] <= inFabric.data;
      instruction <= iMemArr[pc[IMEM_AW+1:2]]; // fetch, one cycle
   end

   always_ff @(posedge Clock) begin
      if (dMem.wrEn && coreInDmem) begin
         for (int b = 0; b < 4; b++) begin
            if (dMem.byteEn[b])
               dMemArr[dMem.address[DMEM_AW+1:2]][8*b +: 8] <= dMem.wrData[8*b +: 8];
         end
      end
      if (fabWr && fabInDmem)
         dMemArr[inFabric.address[DMEM_AW+1:2]] <= inFabric.data; // full word only
   end

   // core load path Q103 -> Q104 -> Q105
   always_ff @(posedge Clock) begin
      if (dMem.rdEn) begin
         if (dMem.address == `CR_KBD_DATA)
            coreRdWordQ104 <= {24'h0, kbdByte};   // head byte
         else if (dMem.address == `CR_KBD_READY)
            coreRdWordQ104 <= {31'h0, kbdReady};
         else if (coreInDmem)
            coreRdWordQ104 <= dMemArr[dMem.address[DMEM_AW+1:2]];
         else
            coreRdWordQ104 <= '0;                // unmapped reads zero
      end
      dMem.rdRsp <= coreRdWordQ104;
   end

   // ======================================================================
   // keyboard control registers
   // ======================================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         kbdScanfEn <= 1'b1;
         kbdPop     <= 1'b0;
      end else begin
         if (dMem.wrEn && dMem.address == `CR_KBD_SCANF_EN)
            kbdScanfEn <= dMem.wrData[0];
         // pop after the head was captured, back-to-back reads see one pop
         kbdPop <= coreRdKbdData && kbdReady && !kbdPop;
      end
   end

   // ======================================================================
   // fabric read pipeline Q503 -> Q504 -> Q505
   // ======================================================================
   always_ff @(posedge Clock) begin
      if (fabRd) begin
         fabRspQ504.opcode    <= FAB_RD_RSP;
         fabRspQ504.srcTileId <= inFabric.tgtTileId; // ids swapped
         fabRspQ504.tgtTileId <= inFabric.srcTileId;
         fabRspQ504.address   <= inFabric.address;
         if (fabInImem)
            fabRspQ504.data <= iMemArr[inFabric.address[IMEM_AW+1:2]];
         else if (fabInDmem)
            fabRspQ504.data <= dMemArr[inFabric.address[DMEM_AW+1:2]];
         else
            fabRspQ504.data <= '0;
      end
      if (outAdvance && fabRspValidQ504)
         outFabric <= fabRspQ504;            // held while fabReady low
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         fabRspValidQ504 <= 1'b0;
         outFabricValid  <= 1'b0;
      end else begin
         if (outAdvance)
            outFabricValid <= fabRspValidQ504;
         if (fabRd)
            fabRspValidQ504 <= 1'b1;
         else if (outAdvance)
            fabRspValidQ504 <= 1'b0;         // moved to output slot
      end
   end

   // response must wait unchanged for the fabric
   outHeldStable: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValid && !fabReady |=> outFabricValid && $stable(outFabric));

endmodule

`default_nettype wire

//--- hw/coreRrvTop.sv
`default_nettype none
`timescale 1ns/100ps

module coreRrvTop (
   input  logic                      Clock,
   input  logic                      arstN,
   input  coreRrvPkg::tTileId        localTileId,
   // ======================================================================
   // core ports, driven by the core or its testbench
   // ======================================================================
   input  coreRrvPkg::tWord          pc,
   output coreRrvPkg::tWord          instruction,
   input  logic                      dMemRdEn,
   input  logic                      dMemWrEn,
   input  coreRrvPkg::tWord          dMemAddress,
   input  coreRrvPkg::tWord          dMemWrData,
   input  coreRrvPkg::tByteEn        dMemByteEn,
   output coreRrvPkg::tWord          dMemRdRsp,
   // ======================================================================
   // fabric
   // ======================================================================
   input  logic                      inFabricValid,
   input  var coreRrvPkg::tTileTrans inFabric,
   output logic                      coreRrvReady,
   output logic                      outFabricValid,
   output coreRrvPkg::tTileTrans     outFabric,
   input  logic                      fabReady,
   // keyboard lines
   input  logic                      kbdClk,
   input  logic                      kbdData
);
   import coreRrvPkg::*;

   tKbdByte kbdByte;                         // head of keyboard queue
   logic    kbdReady;
   logic    kbdPop;                          // core read of kbd data
   logic    kbdScanfEn;

   dMemIf dMemBus ();

   // plain core ports into the data memory bus
   assign dMemBus.rdEn    = dMemRdEn;
   assign dMemBus.wrEn    = dMemWrEn;
   assign dMemBus.address = dMemAddress;
   assign dMemBus.wrData  = dMemWrData;
   assign dMemBus.byteEn  = dMemByteEn;
   assign dMemRdRsp       = dMemBus.rdRsp;

   coreRrvMemWrap uMemWrap (
      .Clock          (Clock),
      .arstN          (arstN),
      .localTileId    (localTileId),
      .pc             (pc),
      .instruction    (instruction),
      .dMem           (dMemBus),
      .inFabricValid  (inFabricValid),
      .inFabric       (inFabric),
      .coreRrvReady   (coreRrvReady),
      .outFabricValid (outFabricValid),
      .outFabric      (outFabric),
      .fabReady       (fabReady),
      .kbdByte        (kbdByte),
      .kbdReady       (kbdReady),
      .kbdPop         (kbdPop),
      .kbdScanfEn     (kbdScanfEn)
   );

   ps2KbdCtrl uKbdCtrl (
      .Clock      (Clock),
      .arstN      (arstN),
      .kbdClk     (kbdClk),
      .kbdData    (kbdData),
      .kbdPop     (kbdPop),
      .kbdScanfEn (kbdScanfEn),
      .kbdByte    (kbdByte),
      .kbdReady   (kbdReady)
   );

endmodule

`default_nettype wire

//--- verif/coreRrvChecker.sv
`default_nettype none
`timescale 1ns/100ps
`include "coreRrv_cfg.svh"

module coreRrvChecker (
   input logic                      Clock,
   input logic                      arstN,
   input coreRrvPkg::tTileId        localTileId,
   input coreRrvPkg::tWord          pc,
   input coreRrvPkg::tWord          instruction,
   input logic                      dMemRdEn,
   input logic                      dMemWrEn,
   input coreRrvPkg::tWord          dMemAddress,
   input coreRrvPkg::tWord          dMemWrData,
   input coreRrvPkg::tByteEn        dMemByteEn,
   input coreRrvPkg::tWord          dMemRdRsp,
   input logic                      inFabricValid,
   input var coreRrvPkg::tTileTrans inFabric,
   input logic                      coreRrvReady,
   input logic                      outFabricValid,
   input var coreRrvPkg::tTileTrans outFabric,
   input logic                      fabReady,
   input logic                      fetchChk,     // this pc is a checked fetch
   input logic                      loadChk,      // this load is checked
   input coreRrvPkg::tWord          tblExp        // table value for the load
);
   import coreRrvPkg::*;

   tWord      model [tWord];                 // keyed by word address
   tTileTrans rspQ [$];                      // expected fabric responses, in order
   tTileTrans expRsp;
   tTileTrans held;                          // response seen under back-pressure
   logic      heldValid = 1'b0;
   logic      ld1V = 1'b0;                   // load pipeline, Q104
   logic      ld2V = 1'b0;                   // Q105
   tWord      ld1E;
   tWord      ld2E;
   logic      f1V = 1'b0;
   tWord      f1E;
   tWord      merged;
   int        errCount = 0;
   int        testErr = 0;
   int        testCount = 0;
   int        testFail = 0;
   int        checkCount = 0;
   int        rspSeen = 0;                   // responses taken by the fabric
   string     curName = "reset";

   function automatic tWord wordAt(tWord a);
      return model.exists(a[31:2]) ? model[a[31:2]] : '0;
   endfunction

   function automatic logic isMapped(tWord a);
      return (a < `IMEM_WORDS * 4) ||
             (a >= `DMEM_BASE && a < `DMEM_BASE + `DMEM_WORDS * 4);
   endfunction

   task automatic startTest(input string name);
      curName = name;
      testErr = 0;
   endtask

   task automatic endTest();
      testCount++;
      if (testErr == 0) begin
         $display("ok    %s", curName);
      end else begin
         testFail++;
         $display("error %s, %0d mismatches", curName, testErr);
      end
   endtask

   task automatic valueCheck(input string what, input logic [81:0] exp,
                             input logic [81:0] act);
      checkCount++;
      if (act !== exp) begin
         errCount++;
         testErr++;
         $display("FAIL %s %s expected %0h actual %0h", curName, what, exp, act);
      end
   endtask

   task automatic flagError(input string msg);
      errCount++;
      testErr++;
      $display("%s in test %s", msg, curName);
   endtask

   task automatic summary();
      $display("tests %0d failed %0d checks %0d errors %0d",
               testCount, testFail, checkCount, errCount);
   endtask

   // ======================================================================
   // sampled on the rising edge, outputs hold last cycle's values
   // ======================================================================
   always @(posedge Clock) begin
      if (arstN) begin
         if (ld2V)
            valueCheck("load", ld2E, dMemRdRsp);        // Q105
         ld2V = ld1V;
         ld2E = ld1E;
         ld1V = dMemRdEn && loadChk;
         ld1E = tblExp;
         if (f1V)
            valueCheck("fetch", f1E, instruction);      // one cycle after pc
         f1V = fetchChk;
         f1E = wordAt(pc);

         if ((dMemRdEn || dMemWrEn) && coreRrvReady)
            flagError("fabric ready stayed high during a core access");

         if (heldValid && outFabric !== held)
            flagError("held fabric response changed");
         heldValid = outFabricValid && !fabReady;
         held      = outFabric;
         if (outFabricValid && fabReady) begin
            if (rspQ.size() == 0)
               flagError("fabric response without a request");
            else
               valueCheck("fabric response", rspQ.pop_front(), outFabric);
            rspSeen++;
         end

         // read old contents before this edge's writes land
         if (inFabricValid && coreRrvReady && inFabric.tgtTileId == localTileId) begin
            if (inFabric.opcode == FAB_RD) begin
               expRsp.opcode    = FAB_RD_RSP;
               expRsp.srcTileId = inFabric.tgtTileId;   // swapped ids
               expRsp.tgtTileId = inFabric.srcTileId;
               expRsp.address   = inFabric.address;
               expRsp.data      = wordAt(inFabric.address);
               rspQ.push_back(expRsp);
            end else if (inFabric.opcode == FAB_WR && isMapped(inFabric.address)) begin
               model[inFabric.address[31:2]] = inFabric.data;
            end
         end

         if (dMemWrEn && dMemAddress >= `DMEM_BASE &&
             dMemAddress < `DMEM_BASE + `DMEM_WORDS * 4) begin
            merged = wordAt(dMemAddress);
            for (int b = 0; b < 4; b++) begin
               if (dMemByteEn[b])
                  merged[8*b +: 8] = dMemWrData[8*b +: 8]; // enabled lanes only
            end
            model[dMemAddress[31:2]] = merged;
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/coreRrvTb.sv
`default_nettype none
`timescale 1ns/100ps
`include "coreRrv_cfg.svh"

module coreRrvTb;
   import coreRrvPkg::*;

   localparam int     OP_FWR   = 0;         // fabric write, this tile
   localparam int     OP_FWRX  = 1;         // fabric write, foreign tile
   localparam int     OP_FRD   = 2;
   localparam int     OP_FETCH = 3;
   localparam int     OP_LOAD  = 4;
   localparam int     OP_STORE = 5;
   localparam int     OP_PS2   = 6;         // data 1 = bad parity
   localparam int     OP_SCANF = 7;
   localparam int     OP_BURST = 8;         // data = number of reads
   localparam int     OP_FRDX  = 9;         // fabric read, foreign tile
   localparam tTileId LOCAL_ID = 8'h05;
   localparam tTileId SRC_ID   = 8'h02;
   localparam tTileId OTHER_ID = 8'h09;
   localparam int     LIMIT    = 2000;      // cycles per wait

   logic      Clock;
   logic      arstN;
   tTileId    localTileId;
   tWord      pc;
   tWord      instruction;
   logic      dMemRdEn;
   logic      dMemWrEn;
   tWord      dMemAddress;
   tWord      dMemWrData;
   tByteEn    dMemByteEn;
   tWord      dMemRdRsp;
   logic      inFabricValid;
   tTileTrans inFabric;
   logic      coreRrvReady;
   logic      outFabricValid;
   tTileTrans outFabric;
   logic      fabReady;
   logic      kbdClk;
   logic      kbdData;
   logic      fetchChk;
   logic      loadChk;
   tWord      tblExp;
   logic      randReady;                    // random back-pressure on

   // stimulus table, one entry per row
   string     rowName [$];
   int        rowOp [$];
   tWord      rowAddr [$];
   tWord      rowData [$];
   tByteEn    rowBe [$];
   tWord      rowExp [$];

   initial Clock = 1'b0;
   always #10 Clock = ~Clock;               // 20 ns

   always @(negedge Clock)
      fabReady <= randReady ? 1'($urandom % 2) : 1'b1;

   coreRrvTop u_dut (
      .Clock(Clock), .arstN(arstN), .localTileId(localTileId),
      .pc(pc), .instruction(instruction),
      .dMemRdEn(dMemRdEn), .dMemWrEn(dMemWrEn), .dMemAddress(dMemAddress),
      .dMemWrData(dMemWrData), .dMemByteEn(dMemByteEn), .dMemRdRsp(dMemRdRsp),
      .inFabricValid(inFabricValid), .inFabric(inFabric), .coreRrvReady(coreRrvReady),
      .outFabricValid(outFabricValid), .outFabric(outFabric), .fabReady(fabReady),
      .kbdClk(kbdClk), .kbdData(kbdData)
   );

   coreRrvChecker u_chk (
      .Clock(Clock), .arstN(arstN), .localTileId(localTileId),
      .pc(pc), .instruction(instruction),
      .dMemRdEn(dMemRdEn), .dMemWrEn(dMemWrEn), .dMemAddress(dMemAddress),
      .dMemWrData(dMemWrData), .dMemByteEn(dMemByteEn), .dMemRdRsp(dMemRdRsp),
      .inFabricValid(inFabricValid), .inFabric(inFabric), .coreRrvReady(coreRrvReady),
      .outFabricValid(outFabricValid), .outFabric(outFabric), .fabReady(fabReady),
      .fetchChk(fetchChk), .loadChk(loadChk), .tblExp(tblExp)
   );

   task automatic addRow(input string n, input int op, input tWord a, input tWord d,
                         input tByteEn be, input tWord e);
      rowName.push_back(n);
      rowOp.push_back(op);
      rowAddr.push_back(a);
      rowData.push_back(d);
      rowBe.push_back(be);
      rowExp.push_back(e);
   endtask

   task automatic timedOut(input string what);
      $display("timeout while waiting for %s", what);
      $display("TEST FAIL");
      $finish;
   endtask

   // enters and leaves on a falling edge
   task automatic fabricSend(input tFabOpcode op, input tTileId tgt, input tWord a,
                             input tWord d);
      int n;
      n = 0;
      inFabricValid      = 1'b1;
      inFabric.opcode    = op;
      inFabric.srcTileId = SRC_ID;
      inFabric.tgtTileId = tgt;
      inFabric.address   = a;
      inFabric.data      = d;
      forever begin
         @(posedge Clock);
         if (coreRrvReady)
            break;                          // accepted on this edge
         n++;
         if (n > LIMIT)
            timedOut("fabric acceptance");
      end
      @(negedge Clock);
      inFabricValid = 1'b0;
   endtask

   task automatic responsesUntil(input int target);
      int n;
      n = 0;
      while (u_chk.rspSeen < target) begin
         @(negedge Clock);
         n++;
         if (n > LIMIT)
            timedOut("fabric responses");
      end
   endtask

   // load data lands two cycles after the request edge
   task automatic coreOp(input logic rd, input logic wr, input tWord a, input tWord d,
                         input tByteEn be, input tWord e);
      dMemRdEn    = rd;
      dMemWrEn    = wr;
      dMemAddress = a;
      dMemWrData  = d;
      dMemByteEn  = be;
      loadChk     = rd;
      tblExp      = e;
      @(negedge Clock);
      dMemRdEn = 1'b0;
      dMemWrEn = 1'b0;
      loadChk  = 1'b0;
      repeat (2) @(negedge Clock);
   endtask

   task automatic ps2Bit(input logic b);
      kbdData = b;
      repeat (8) @(negedge Clock);          // slow bit clock
      kbdClk = 1'b0;
      repeat (8) @(negedge Clock);
      kbdClk = 1'b1;
   endtask

   task automatic ps2Frame(input tKbdByte code, input logic badParity);
      ps2Bit(1'b0);                         // start
      for (int i = 0; i < 8; i++)
         ps2Bit(code[i]);
      ps2Bit(badParity ? ^code : ~^code);   // odd parity
      ps2Bit(1'b1);                         // stop
      repeat (16) @(negedge Clock);         // idle, byte reaches the queue
   endtask

   task automatic runRow(input int i);
      int target;
      u_chk.startTest(rowName[i]);
      case (rowOp[i])
         OP_FWR:  fabricSend(FAB_WR, LOCAL_ID, rowAddr[i], rowData[i]);
         OP_FWRX: fabricSend(FAB_WR, OTHER_ID, rowAddr[i], rowData[i]);
         OP_FRD: begin
            target = u_chk.rspSeen + 1;
            fabricSend(FAB_RD, LOCAL_ID, rowAddr[i], '0);
            responsesUntil(target);
         end
         OP_FRDX: begin
            fabricSend(FAB_RD, OTHER_ID, rowAddr[i], '0);
            repeat (4) @(negedge Clock);    // past the two-cycle response slot
         end
         OP_FETCH: begin
            pc       = rowAddr[i];
            fetchChk = 1'b1;
            @(negedge Clock);
            fetchChk = 1'b0;
            @(negedge Clock);
         end
         OP_LOAD:  coreOp(1'b1, 1'b0, rowAddr[i], '0, 4'h0, rowExp[i]);
         OP_STORE: coreOp(1'b0, 1'b1, rowAddr[i], rowData[i], rowBe[i], '0);
         OP_SCANF: coreOp(1'b0, 1'b1, `CR_KBD_SCANF_EN, rowData[i], 4'hF, '0);
         OP_PS2:   ps2Frame(rowAddr[i][7:0], rowData[i][0]);
         OP_BURST: begin
            randReady = 1'b1;
            for (int k = 0; k < 4; k++)
               fabricSend(FAB_WR, LOCAL_ID, rowAddr[i] + 4 * k, $urandom);
            target = u_chk.rspSeen + int'(rowData[i]);
            for (int k = 0; k < int'(rowData[i]); k++)
               fabricSend(FAB_RD, LOCAL_ID, rowAddr[i] + 4 * (k % 4), '0);
            responsesUntil(target);
            randReady = 1'b0;
         end
         default: u_chk.flagError($sformatf("unknown operation in row %0d", i));
      endcase
      u_chk.endTest();
   endtask

   initial begin
      void'($urandom(97));
      arstN = 1'b0;
      localTileId = LOCAL_ID;
      pc = '0;
      dMemRdEn = 1'b0;
      dMemWrEn = 1'b0;
      dMemAddress = '0;
      dMemWrData = '0;
      dMemByteEn = '0;
      inFabricValid = 1'b0;
      inFabric = '0;
      fabReady = 1'b1;
      kbdClk = 1'b1;                        // idle lines high
      kbdData = 1'b1;
      fetchChk = 1'b0;
      loadChk = 1'b0;
      tblExp = '0;
      randReady = 1'b0;

      // name, op, address or byte, data, byte enables, expected
      addRow("fabWrImem",   OP_FWR,   32'h0010, 32'hDEADBEEF, 4'hF, '0);
      addRow("fabWrDmem",   OP_FWR,   32'h1020, 32'h12345678, 4'hF, '0);
      addRow("fabRdImem",   OP_FRD,   32'h0010, '0, 4'h0, '0);
      addRow("fabRdDmem",   OP_FRD,   32'h1020, '0, 4'h0, '0);
      addRow("fabWrForeign", OP_FWRX, 32'h1020, 32'hFFFFFFFF, 4'hF, '0);
      addRow("fabRdForeign", OP_FRDX, 32'h1020, '0, 4'h0, '0);
      addRow("fabRdAfterForeign", OP_FRD, 32'h1020, '0, 4'h0, '0);
      addRow("fetch",       OP_FETCH, 32'h0010, '0, 4'h0, 32'hDEADBEEF);
      addRow("storeLanes02", OP_STORE, 32'h1020, 32'hAABBCCDD, 4'b0101, '0);
      addRow("loadMerged",  OP_LOAD,  32'h1020, '0, 4'h0, 32'h12BB56DD);
      addRow("storeLane1",  OP_STORE, 32'h1020, 32'h0000EE00, 4'b0010, '0);
      addRow("loadMerged2", OP_LOAD,  32'h1020, '0, 4'h0, 32'h12BBEEDD);
      addRow("fabRdStored", OP_FRD,   32'h1020, '0, 4'h0, '0);
      addRow("backPressure", OP_BURST, 32'h1100, 32'd12, 4'h0, '0);
      addRow("ps2Frame1C",  OP_PS2,   32'h1C, 32'd0, 4'h0, '0);
      addRow("ps2Frame32",  OP_PS2,   32'h32, 32'd0, 4'h0, '0);
      addRow("ps2BadParity", OP_PS2,  32'h55, 32'd1, 4'h0, '0);
      addRow("kbdReady1",   OP_LOAD,  `CR_KBD_READY, '0, 4'h0, 32'd1);
      addRow("kbdData1C",   OP_LOAD,  `CR_KBD_DATA, '0, 4'h0, 32'h1C);
      addRow("kbdReady2",   OP_LOAD,  `CR_KBD_READY, '0, 4'h0, 32'd1);
      addRow("kbdData32",   OP_LOAD,  `CR_KBD_DATA, '0, 4'h0, 32'h32);
      addRow("kbdDrained",  OP_LOAD,  `CR_KBD_READY, '0, 4'h0, 32'd0);
      addRow("scanfOff",    OP_SCANF, '0, 32'd0, 4'h0, '0);
      addRow("ps2Ignored",  OP_PS2,   32'h2A, 32'd0, 4'h0, '0);
      addRow("kbdStillEmpty", OP_LOAD, `CR_KBD_READY, '0, 4'h0, 32'd0);
      addRow("scanfOn",     OP_SCANF, '0, 32'd1, 4'h0, '0);
      addRow("ps2Frame4B",  OP_PS2,   32'h4B, 32'd0, 4'h0, '0);
      addRow("kbdReady3",   OP_LOAD,  `CR_KBD_READY, '0, 4'h0, 32'd1);
      addRow("kbdData4B",   OP_LOAD,  `CR_KBD_DATA, '0, 4'h0, 32'h4B);
      addRow("kbdEmptyEnd", OP_LOAD,  `CR_KBD_READY, '0, 4'h0, 32'd0);

      repeat (5) @(negedge Clock);
      arstN = 1'b1;
      repeat (2) @(negedge Clock);

      for (int i = 0; i < rowOp.size(); i++)
         runRow(i);

      repeat (4) @(negedge Clock);
      u_chk.summary();
      if (u_chk.errCount == 0 && u_chk.rspQ.size() == 0) begin
         $display("TEST PASS");
      end else begin
         if (u_chk.rspQ.size() != 0)
            $display("%0d fabric responses never arrived", u_chk.rspQ.size());
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- coreRrv.f
+incdir+include
hw/coreRrvPkg.sv
hw/dMemIf.sv
hw/ps2KbdCtrl.sv
hw/coreRrvMemWrap.sv
hw/coreRrvTop.sv
verif/coreRrvChecker.sv
verif/coreRrvTb.sv

//--- Bender.yml
package:
  name: coreRrv

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/coreRrvPkg.sv
      - hw/dMemIf.sv
      - hw/ps2KbdCtrl.sv
      - hw/coreRrvMemWrap.sv
      - hw/coreRrvTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/coreRrvChecker.sv
      - verif/coreRrvTb.sv
